//--- logic/irq_pkg.sv
// Shared constants and types for the machine-mode interrupt controller
package irq_pkg;

  // ----------------------------------------------------------
  // Interrupt lines
  // ----------------------------------------------------------
  localparam int NUM_IRQ = 32;

  // Implemented lines: platform 31..16, MEI 11, MTI 7, MSI 3
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK_DEFAULT = 32'hffff_0888;

  // ----------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------
  localparam int APB_AW = 8;

  // Byte offsets of the three CSRs
  localparam logic [APB_AW-1:0] ADDR_MIE     = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_MSTATUS = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_MIP     = 8'h08;

  // Global enable position inside MSTATUS
  localparam int MSTATUS_MIE_BIT = 3;

  // ----------------------------------------------------------
  // Interrupt word, seen raw or by field
  // ----------------------------------------------------------
  typedef struct packed {
    logic [15:0] platform;  // Lines 31 down to 16
    logic [3:0]  rsv_hi;
    logic        mei;       // Machine external, line 11
    logic [2:0]  rsv_mid;
    logic        mti;       // Machine timer, line 7
    logic [2:0]  rsv_lo;
    logic        msi;       // Machine software, line 3
    logic [2:0]  rsv_0;
  } irq_fields_t;

  typedef union packed {
    logic [NUM_IRQ-1:0] raw;
    irq_fields_t        fields;
  } irq_vec_u;

  typedef logic [$clog2(NUM_IRQ)-1:0] irq_id_t;

  // Core status, already qualified by the core
  typedef struct packed {
    logic wfi;        // WFI retired this cycle
    logic pipe_idle;  // No fetch, load or store outstanding
  } core_status_t;

  // Acknowledge towards the core
  typedef struct packed {
    logic    ack;
    irq_id_t id;
  } irq_ack_t;

  typedef enum logic [1:0] {
    WFI_RUN   = 2'd0,
    WFI_WAIT  = 2'd1,
    WFI_SLEEP = 2'd2
  } wfi_state_e;

endpackage

//--- logic/irq_csr_regs.sv
// APB register block holding MIE, MSTATUS.MIE and the registered pending word
`timescale 1ns/100ps

module irq_csr_regs #(
  parameter logic [irq_pkg::NUM_IRQ-1:0] VALID_IRQ_MASK = irq_pkg::VALID_IRQ_MASK_DEFAULT
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // APB slave, zero wait states
  input  logic [irq_pkg::APB_AW-1:0]  paddr_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [irq_pkg::NUM_IRQ-1:0] pwdata_i,
  output logic [irq_pkg::NUM_IRQ-1:0] prdata_o,
  output logic                        pslverr_o,
  // Interrupt lines and hardware clear
  input  logic [irq_pkg::NUM_IRQ-1:0] irq_i,
  input  logic                        hw_clear_mie_i,
  // Register state
  output irq_pkg::irq_vec_u           mip_o,
  output irq_pkg::irq_vec_u           mie_o,
  output logic                        mstatus_mie_o,
  output logic                        irq_pending_enabled_o
);

  import irq_pkg::*;

  irq_vec_u mip_q;
  irq_vec_u mie_q;
  logic     mstatus_mie_q;
  logic     apb_access;
  logic     addr_hit;
  logic     wr_mie;
  logic     wr_mstatus;

  // ----------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------
  // Access phase only
  assign apb_access = psel_i & penable_i;

  assign wr_mie     = apb_access & pwrite_i & (paddr_i == ADDR_MIE);
  assign wr_mstatus = apb_access & pwrite_i & (paddr_i == ADDR_MSTATUS);

  // Read mux, also flags the mapped offsets
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      ADDR_MIE:     prdata_o = mie_q.raw;
      ADDR_MSTATUS: prdata_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
      ADDR_MIP:     prdata_o = mip_q.raw;
      default:      addr_hit = 1'b0;
    endcase
  end

  // Unmapped offset or write to read-only MIP
  assign pslverr_o = apb_access & (~addr_hit | (pwrite_i & (paddr_i == ADDR_MIP)));

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q         <= '0;
      mie_q         <= '0;
      mstatus_mie_q <= 1'b0;
    end else begin
      // Pending follows the lines one cycle late, reserved bits dropped
      mip_q.raw <= irq_i & VALID_IRQ_MASK;
      if (wr_mie) begin
        mie_q.raw <= pwdata_i & VALID_IRQ_MASK;
      end
      // Taking an interrupt beats a software write in the same cycle
      if (hw_clear_mie_i) begin
        mstatus_mie_q <= 1'b0;
      end else if (wr_mstatus) begin
        mstatus_mie_q <= pwdata_i[MSTATUS_MIE_BIT];
      end
    end
  end

  assign mip_o         = mip_q;
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

  // Wake source for the WFI FSM, ignores the global enable
  assign irq_pending_enabled_o = |(mip_q.raw & mie_q.raw);

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------
  // Reserved lines never show up as pending
  a_mip_not_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mip_q.raw & ~VALID_IRQ_MASK) == '0
  );

endmodule

//--- logic/irq_priority_arb.sv
// Fixed-priority arbiter picking the winning pending and enabled interrupt
`timescale 1ns/100ps

module irq_priority_arb (
  input  irq_pkg::irq_vec_u mip_i,
  input  irq_pkg::irq_vec_u mie_i,
  output logic              win_valid_o,
  output irq_pkg::irq_id_t  win_id_o
);

  import irq_pkg::*;

  // Line numbers of the standard machine interrupts
  localparam irq_id_t ID_PLATFORM_BASE = 5'd16;
  localparam irq_id_t ID_MEI           = 5'd11;
  localparam irq_id_t ID_MSI           = 5'd3;
  localparam irq_id_t ID_MTI           = 5'd7;

  irq_vec_u active;

  // Candidates must be both pending and enabled
  assign active.raw = mip_i.raw & mie_i.raw;

  // ----------------------------------------------------------
  // Priority scan
  // ----------------------------------------------------------
  // Order: platform 31..16, then MEI, then MSI, then MTI
  always_comb begin
    win_valid_o = 1'b1;
    win_id_o    = '0;
    if (|active.fields.platform) begin
      // Ascending scan, so the highest set line is kept last
      for (int i = 0; i < 16; i++) begin
        if (active.fields.platform[i]) begin
          win_id_o = ID_PLATFORM_BASE + irq_id_t'(i);
        end
      end
    end else if (active.fields.mei) begin
      win_id_o = ID_MEI;
    end else if (active.fields.msi) begin
      win_id_o = ID_MSI;
    end else if (active.fields.mti) begin
      win_id_o = ID_MTI;
    end else begin
      // Nothing to take
      win_valid_o = 1'b0;
    end

    // Winner must be pending and enabled in the input words
    if (win_valid_o) begin
      a_win_is_active: assert (mip_i.raw[win_id_o] && mie_i.raw[win_id_o]);
    end
  end

endmodule

//--- logic/irq_ack_ctrl.sv
// Acknowledge generator issuing a one-cycle acknowledge with the winning ID
`timescale 1ns/100ps

module irq_ack_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              irq_take_i,
  input  logic              win_valid_i,
  input  irq_pkg::irq_id_t  win_id_i,
  input  logic              mstatus_mie_i,
  output irq_pkg::irq_ack_t irq_ack_o,
  output logic              hw_clear_mie_o
);

  import irq_pkg::*;

  irq_ack_t ack_q;
  logic     take;

  // Core at a boundary, something to take, globally enabled
  assign take = irq_take_i & win_valid_i & mstatus_mie_i;

  // Same edge that registers the acknowledge drops MSTATUS.MIE
  assign hw_clear_mie_o = take;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= '0;
    end else begin
      ack_q.ack <= take;
      if (take) begin
        ack_q.id <= win_id_i;
      end
    end
  end

  assign irq_ack_o = ack_q;

  // Relies on the clear reaching the register block in time
  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ack_q.ack |=> !ack_q.ack
  );

endmodule

//--- logic/wfi_sleep_fsm.sv
// WFI state machine moving between run, wait-for-idle and sleep
`timescale 1ns/100ps

module wfi_sleep_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  irq_pkg::core_status_t core_status_i,
  input  logic                  irq_pending_enabled_i,
  input  logic                  delay_done_i,
  output logic                  count_en_o,
  output logic                  core_sleep_o
);

  import irq_pkg::*;

  wfi_state_e state_q;
  wfi_state_e state_d;

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      WFI_RUN: begin
        // Retired WFI starts the wait for an idle pipeline
        if (core_status_i.wfi) begin
          state_d = WFI_WAIT;
        end
      end
      WFI_WAIT: begin
        // Wake has priority over the sleep delay
        if (irq_pending_enabled_i) begin
          state_d = WFI_RUN;
        end else if (delay_done_i) begin
          state_d = WFI_SLEEP;
        end
      end
      WFI_SLEEP: begin
        // Any pending and enabled line wakes, global enable ignored
        if (irq_pending_enabled_i) begin
          state_d = WFI_RUN;
        end
      end
      default: state_d = WFI_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  // Timer restarts whenever the pipeline is busy
  assign count_en_o = (state_q == WFI_WAIT) & core_status_i.pipe_idle;

  // Decoded from the state register, rises and falls on an edge
  assign core_sleep_o = (state_q == WFI_SLEEP);

  // Sleep is never entered straight from run
  a_no_sleep_from_run: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == WFI_RUN) |=> !core_sleep_o
  );

endmodule

//--- logic/sleep_delay_timer.sv
// Idle-cycle counter that flags when the sleep latency has elapsed
`timescale 1ns/100ps

module sleep_delay_timer #(
  parameter int SLEEP_LATENCY = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic count_en_i,
  output logic done_o
);

  // At least one bit even for a zero latency
  localparam int CW = (SLEEP_LATENCY < 1) ? 1 : $clog2(SLEEP_LATENCY + 1);
  localparam logic [CW-1:0] CNT_MAX = CW'(SLEEP_LATENCY);

  logic [CW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!count_en_i) begin
      // Busy pipeline or left the wait state
      cnt_q <= '0;
    end else if (cnt_q != CNT_MAX) begin
      // Saturates at the latency
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Only meaningful while still counting
  assign done_o = count_en_i & (cnt_q == CNT_MAX);

endmodule

//--- logic/irq_ctrl_top.sv
// Machine-mode interrupt controller with WFI sleep control
`timescale 1ns/100ps

module irq_ctrl_top #(
  parameter logic [irq_pkg::NUM_IRQ-1:0] VALID_IRQ_MASK = irq_pkg::VALID_IRQ_MASK_DEFAULT,
  parameter int                          SLEEP_LATENCY  = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // APB slave
  input  logic [irq_pkg::APB_AW-1:0]  paddr_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [irq_pkg::NUM_IRQ-1:0] pwdata_i,
  output logic [irq_pkg::NUM_IRQ-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // Interrupts and core handshake
  input  logic [irq_pkg::NUM_IRQ-1:0] irq_i,
  input  logic                        irq_take_i,
  input  irq_pkg::core_status_t       core_status_i,
  output irq_pkg::irq_ack_t           irq_ack_o,
  output logic                        core_sleep_o
);

  import irq_pkg::*;

  irq_vec_u mip;
  irq_vec_u mie;
  logic     mstatus_mie;
  logic     irq_pending_enabled;
  logic     win_valid;
  irq_id_t  win_id;
  logic     hw_clear_mie;
  logic     count_en;
  logic     delay_done;

  // No wait states
  assign pready_o = 1'b1;

  // ----------------------------------------------------------
  // Registers and arbitration
  // ----------------------------------------------------------
  irq_csr_regs #(
    .VALID_IRQ_MASK(VALID_IRQ_MASK)
  ) i_irq_csr_regs (
    .clk_i, .rst_ni, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pslverr_o, .irq_i,
    .hw_clear_mie_i       (hw_clear_mie),
    .mip_o                (mip),
    .mie_o                (mie),
    .mstatus_mie_o        (mstatus_mie),
    .irq_pending_enabled_o(irq_pending_enabled)
  );

  irq_priority_arb i_irq_priority_arb (
    .mip_i(mip), .mie_i(mie), .win_valid_o(win_valid), .win_id_o(win_id)
  );

  irq_ack_ctrl i_irq_ack_ctrl (
    .clk_i, .rst_ni, .irq_take_i, .irq_ack_o,
    .win_valid_i   (win_valid),
    .win_id_i      (win_id),
    .mstatus_mie_i (mstatus_mie),
    .hw_clear_mie_o(hw_clear_mie)
  );

  // ----------------------------------------------------------
  // WFI sleep control
  // ----------------------------------------------------------
  wfi_sleep_fsm i_wfi_sleep_fsm (
    .clk_i, .rst_ni, .core_status_i, .core_sleep_o,
    .irq_pending_enabled_i(irq_pending_enabled),
    .delay_done_i         (delay_done),
    .count_en_o           (count_en)
  );

  sleep_delay_timer #(
    .SLEEP_LATENCY(SLEEP_LATENCY)
  ) i_sleep_delay_timer (
    .clk_i, .rst_ni, .count_en_i(count_en), .done_o(delay_done)
  );

endmodule

//--- tests/irq_ctrl_tb.sv
// Directed testbench for the machine-mode interrupt controller with WFI sleep control
`timescale 1ns/100ps

module irq_ctrl_tb;

  import irq_pkg::*;

  // Implemented lines as listed for the platform
  localparam logic [31:0] VALID_MASK    = 32'hffff_0888;
  localparam int          SLEEP_LATENCY = 2;
  localparam int          SLEEP_LIMIT   = 20;
  // Per-test budgets: reset, regs, pending, priority, gating, sleep, wake
  localparam int          BUDGET_CYCLES = 10 + 80 + 50 + 130 + 50 + 60 + 50;
  localparam int          WATCHDOG_NS   = BUDGET_CYCLES * 10 * 2;

  logic         clk_i;
  logic         rst_ni;
  logic [7:0]   paddr_i;
  logic         psel_i;
  logic         penable_i;
  logic         pwrite_i;
  logic [31:0]  pwdata_i;
  logic [31:0]  prdata_o;
  logic         pready_o;
  logic         pslverr_o;
  logic [31:0]  irq_i;
  logic         irq_take_i;
  core_status_t core_status_i;
  irq_ack_t     irq_ack_o;
  logic         core_sleep_o;

  int           errors;
  int           checks;
  logic [31:0]  rng_state;

  irq_ctrl_top #(
    .VALID_IRQ_MASK(VALID_MASK),
    .SLEEP_LATENCY (SLEEP_LATENCY)
  ) i_irq_ctrl_top (
    .clk_i, .rst_ni, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o, .irq_i, .irq_take_i, .core_status_i,
    .irq_ack_o, .core_sleep_o
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Numerical Recipes LCG constants
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Scan order 31 down to 16, then 11, 3, 7; -1 when nothing is active
  function automatic int expected_winner(input logic [31:0] active);
    for (int i = 31; i >= 16; i--) begin
      if (active[i]) return i;
    end
    if (active[11]) return 11;
    if (active[3]) return 3;
    if (active[7]) return 7;
    return -1;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // ID only matters when an acknowledge is expected
  task automatic check_ack(input irq_ack_t got, input irq_ack_t exp);
    checks++;
    if (got.ack !== exp.ack || (exp.ack && got.id !== exp.id)) begin
      errors++;
      $display("Fail irq_ack_o: got 0x%h expected 0x%h", got, exp);
    end
  endtask

  // Setup on one falling edge, access on the next, sampled before the rising edge
  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk_i);
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = wdata;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #1;
    rdata = prdata_o;
    err   = pslverr_o;
    // Zero wait states, ready in every access phase
    check_bit("pready_o", pready_o, 1'b1);
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    check_bit("pslverr_o", err, exp_err);
  endtask

  task automatic expect_read(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    check_bit("pslverr_o", err, 1'b0);
    check_word(name, rdata, exp);
  endtask

  // Take held for two edges, only the first may acknowledge
  task automatic take_and_check(input int winner);
    irq_ack_t exp;
    @(negedge clk_i);
    irq_take_i = 1'b1;
    @(negedge clk_i);
    exp.ack = (winner >= 0);
    exp.id  = irq_id_t'(winner);
    check_ack(irq_ack_o, exp);
    @(negedge clk_i);
    exp.ack = 1'b0;
    check_ack(irq_ack_o, exp);
    irq_take_i = 1'b0;
  endtask

  // Counts falling edges from start until sleep, bounded
  task automatic wait_sleep(input int start, output int edges);
    edges = start;
    while (!core_sleep_o && edges < SLEEP_LIMIT) begin
      @(negedge clk_i);
      edges++;
    end
    if (!core_sleep_o) begin
      errors++;
      $display("Error: core_sleep_o did not rise within %0d cycles", SLEEP_LIMIT);
    end
  endtask

  task automatic enter_sleep();
    int edges;
    @(negedge clk_i);
    core_status_i.wfi       = 1'b1;
    core_status_i.pipe_idle = 1'b1;
    @(negedge clk_i);
    core_status_i.wfi = 1'b0;
    wait_sleep(0, edges);
  endtask

  // Wake through line 3, then leave nothing enabled
  task automatic leave_sleep();
    int edges;
    write_reg(ADDR_MIE, 32'h0000_0008, 1'b0);
    @(negedge clk_i);
    irq_i = 32'h0000_0008;
    edges = 0;
    while (core_sleep_o && edges < SLEEP_LIMIT) begin
      @(negedge clk_i);
      edges++;
    end
    if (core_sleep_o) begin
      errors++;
      $display("Error: core_sleep_o stayed high after an enabled line rose");
    end
    irq_i = '0;
    write_reg(ADDR_MIE, '0, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic test_reset();
    check_ack(irq_ack_o, '0);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    check_bit("pslverr_o", pslverr_o, 1'b0);
    expect_read("mie", ADDR_MIE, '0);
    expect_read("mstatus", ADDR_MSTATUS, '0);
    expect_read("mip", ADDR_MIP, '0);
  endtask

  task automatic test_registers();
    logic [31:0] w;
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < 4; i++) begin
      w = next_rand();
      write_reg(ADDR_MIE, w, 1'b0);
      expect_read("mie", ADDR_MIE, w & VALID_MASK);
    end
    // Only bit 3 of MSTATUS is implemented
    write_reg(ADDR_MSTATUS, 32'hffff_ffff, 1'b0);
    expect_read("mstatus", ADDR_MSTATUS, 32'h0000_0008);
    write_reg(ADDR_MSTATUS, 32'hffff_fff7, 1'b0);
    expect_read("mstatus", ADDR_MSTATUS, '0);
    // MIP is read-only
    irq_i = '0;
    write_reg(ADDR_MIP, 32'hffff_ffff, 1'b1);
    expect_read("mip", ADDR_MIP, '0);
    // Unmapped offset leaves MIE alone
    write_reg(ADDR_MIE, 32'h0000_0800, 1'b0);
    write_reg(8'h10, 32'hffff_ffff, 1'b1);
    apb_access(8'h10, 1'b0, '0, rdata, err);
    check_bit("pslverr_o", err, 1'b1);
    expect_read("mie", ADDR_MIE, 32'h0000_0800);
    write_reg(ADDR_MIE, '0, 1'b0);
  endtask

  task automatic test_pending();
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      w = next_rand();
      @(negedge clk_i);
      irq_i = w;
      expect_read("mip", ADDR_MIP, w & VALID_MASK);
    end
    irq_i = '0;
  endtask

  task automatic test_priority();
    logic [31:0] mie_w;
    logic [31:0] irq_w;
    logic [31:0] sel;
    for (int i = 0; i < 10; i++) begin
      mie_w = next_rand();
      irq_w = next_rand();
      sel   = next_rand();
      // Knock out higher classes so the lower ones get their turn
      case (sel[1:0])
        2'd1: irq_w = irq_w & 32'h0000_ffff;
        2'd2: irq_w = irq_w & 32'h0000_f7ff;
        2'd3: irq_w = irq_w & 32'h0000_f7f7;
        default: irq_w = irq_w;
      endcase
      write_reg(ADDR_MIE, mie_w, 1'b0);
      @(negedge clk_i);
      irq_i = irq_w;
      write_reg(ADDR_MSTATUS, 32'h0000_0008, 1'b0);
      take_and_check(expected_winner(irq_w & mie_w & VALID_MASK));
    end
    irq_i = '0;
  endtask

  task automatic test_gating();
    write_reg(ADDR_MIE, 32'h0000_0800, 1'b0);
    write_reg(ADDR_MSTATUS, '0, 1'b0);
    @(negedge clk_i);
    irq_i = 32'h0000_0800;
    take_and_check(-1);
    write_reg(ADDR_MSTATUS, 32'h0000_0008, 1'b0);
    take_and_check(11);
    // Hardware cleared the global enable on the acknowledge
    expect_read("mstatus", ADDR_MSTATUS, '0);
    take_and_check(-1);
    irq_i = '0;
    write_reg(ADDR_MIE, '0, 1'b0);
  endtask

  task automatic test_sleep_entry();
    int edges;
    // WAIT at edge T, sleep at T + latency + 1
    @(negedge clk_i);
    core_status_i.wfi       = 1'b1;
    core_status_i.pipe_idle = 1'b1;
    @(negedge clk_i);
    core_status_i.wfi = 1'b0;
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    wait_sleep(0, edges);
    check_word("sleep_edges", edges, SLEEP_LATENCY + 1);
    leave_sleep();
    // One idle count, two busy edges restart it, then a full latency
    @(negedge clk_i);
    core_status_i.wfi = 1'b1;
    @(negedge clk_i);
    core_status_i.wfi = 1'b0;
    @(negedge clk_i);
    core_status_i.pipe_idle = 1'b0;
    @(negedge clk_i);
    @(negedge clk_i);
    core_status_i.pipe_idle = 1'b1;
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    wait_sleep(3, edges);
    check_word("sleep_edges", edges, SLEEP_LATENCY + 4);
    leave_sleep();
  endtask

  task automatic test_wake();
    write_reg(ADDR_MSTATUS, '0, 1'b0);
    write_reg(ADDR_MIE, 32'h0000_0800, 1'b0);
    enter_sleep();
    // Line 7 is not enabled and line 0 is reserved
    @(negedge clk_i);
    irq_i = 32'h0000_0081;
    repeat (4) begin
      @(negedge clk_i);
      check_bit("core_sleep_o", core_sleep_o, 1'b1);
    end
    irq_i = 32'h0000_0881;
    @(negedge clk_i);
    check_bit("core_sleep_o", core_sleep_o, 1'b1);
    @(negedge clk_i);
    check_bit("core_sleep_o", core_sleep_o, 1'b0);
    check_ack(irq_ack_o, '0);
    irq_i = '0;
    write_reg(ADDR_MIE, '0, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    paddr_i       = '0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    pwdata_i      = '0;
    irq_i         = '0;
    irq_take_i    = 1'b0;
    core_status_i = '0;
    errors        = 0;
    checks        = 0;
    rng_state     = 32'ha670b06f;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_registers();
    test_pending();
    test_priority();
    test_gating();
    test_sleep_entry();
    test_wake();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- project.f
logic/irq_pkg.sv
logic/irq_csr_regs.sv
logic/irq_priority_arb.sv
logic/irq_ack_ctrl.sv
logic/wfi_sleep_fsm.sv
logic/sleep_delay_timer.sv
logic/irq_ctrl_top.sv
tests/irq_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert \
  --top-module irq_ctrl_tb \
  -f project.f \
  -Mdir "$BUILD_DIR" \
  -o irq_ctrl_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/irq_ctrl_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
exit 0
